// File: mem_pkg.sv
package mem_pkg;

	// ********************
	// Memory geometry
	// ********************

	// Byte address width, 1024 bytes in total
	localparam int mem_addr_width = 10;

	// Word index into each bank, 256 entries per bank
	localparam int bank_addr_width = 8;

	// Byte lanes per 32-bit word
	localparam int num_lanes = 4;

	// ********************
	// Access codes
	// ********************

	// Store size, store_none means the access is a read
	typedef enum logic [2:0] {
		store_none = 3'b000,
		store_byte = 3'b001,
		store_half = 3'b010,
		store_word = 3'b100
	} store_op_t;

	// Load size and extension, encoded like the RISC-V funct3 field
	typedef enum logic [2:0] {
		load_byte   = 3'b000,
		load_half   = 3'b001,
		load_word   = 3'b010,
		load_byte_u = 3'b100,
		load_half_u = 3'b101
	} load_op_t;

endpackage

// File: byte_bank.sv
`timescale 1ns/1ps

module byte_bank import mem_pkg::*; (
	input  logic                       clk,
	input  logic                       en,
	input  logic                       we,
	input  logic [bank_addr_width-1:0] addr,
	input  logic [7:0]                 din,
	output logic [7:0]                 dout
);

	logic [7:0] ram [0:(1 << bank_addr_width) - 1];

	// Read returns the old contents when the same entry is written
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				ram[addr] <= din;
			end
			dout <= ram[addr];
		end
	end

endmodule

// File: mem_interface.sv
`timescale 1ns/1ps

module mem_interface import mem_pkg::*; (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      en,
	input  logic [mem_addr_width-1:0] addr,
	input  logic [31:0]               wdata,
	input  store_op_t                 store,
	output logic [31:0]               rdata
);

	logic [bank_addr_width-1:0] word_idx;
	logic [bank_addr_width-1:0] next_idx;
	logic [1:0]                 offset;
	logic [1:0]                 offset_q;
	logic [num_lanes-1:0]       size_mask;
	logic [2*num_lanes-1:0]     shifted_mask;
	logic [num_lanes-1:0]       lane_we;
	logic [7:0]                 bank_dout [num_lanes];

	assign offset   = addr[1:0];
	assign word_idx = addr[mem_addr_width-1:2];

	// Wraps to entry 0 past the top of the banks
	assign next_idx = word_idx + 1'b1;

	// ********************
	// Lane write enables
	// ********************

	always_comb begin
		case (store)
			store_byte: size_mask = 4'b0001;
			store_half: size_mask = 4'b0011;
			store_word: size_mask = 4'b1111;
			default:    size_mask = 4'b0000;
		endcase

		// Bits pushed past lane 3 come back in at lane 0
		shifted_mask = {4'b0000, size_mask} << offset;
		lane_we = shifted_mask[2*num_lanes-1:num_lanes] | shifted_mask[num_lanes-1:0];
	end

	// ********************
	// Lane steering
	// ********************

	for (genvar i = 0; i < num_lanes; i++) begin : g_lane
		logic [1:0]                 pos;
		logic [bank_addr_width-1:0] lane_addr;
		logic [7:0]                 lane_din;

		// Position of this lane's byte within the access
		assign pos = 2'(i) - offset;

		// Lanes below the offset hold the tail of the access in the next word
		assign lane_addr = (2'(i) < offset) ? next_idx : word_idx;
		assign lane_din  = wdata[8*pos +: 8];

		byte_bank u_bank (
			.clk  (clk),
			.en   (en),
			.we   (lane_we[i]),
			.addr (lane_addr),
			.din  (lane_din),
			.dout (bank_dout[i])
		);
	end

	// ********************
	// Read path
	// ********************

	// The offset travels with the read so the rotation matches the returning data
	always_ff @(posedge clk) begin
		if (reset) begin
			offset_q <= 2'b00;
		end else if (en) begin
			offset_q <= offset;
		end
	end

	for (genvar k = 0; k < num_lanes; k++) begin : g_rotate
		assign rdata[8*k +: 8] = bank_dout[2'(k) + offset_q];
	end

endmodule

// File: mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter import mem_pkg::*; (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      fetch_req,
	input  logic [mem_addr_width-1:0] fetch_addr,
	input  logic                      data_req,
	input  logic [mem_addr_width-1:0] data_addr,
	input  store_op_t                 data_store,
	input  logic [31:0]               data_wdata,
	output logic                      fetch_grant,
	output logic                      data_grant,
	output logic                      mem_en,
	output logic [mem_addr_width-1:0] mem_addr,
	output store_op_t                 mem_store,
	output logic [31:0]               mem_wdata,
	output logic                      fetch_valid,
	output logic                      data_valid,
	output logic                      load_capture
);

	logic contest;
	logic data_won_last;

	// ********************
	// Grant selection
	// ********************

	assign contest = fetch_req & data_req;

	// On contest the loser of the previous contest goes first
	assign data_grant  = data_req & (~fetch_req | ~data_won_last);
	assign fetch_grant = fetch_req & ~data_grant;

	assign mem_en    = fetch_grant | data_grant;
	assign mem_addr  = data_grant ? data_addr : fetch_addr;
	assign mem_store = data_grant ? data_store : store_none;
	assign mem_wdata = data_wdata;

	assign load_capture = data_grant & (data_store == store_none);

	// Only contested cycles move the winner history
	always_ff @(posedge clk) begin
		if (reset) begin
			data_won_last <= 1'b0;
		end else if (contest) begin
			data_won_last <= data_grant;
		end
	end

	// ********************
	// Response ownership
	// ********************

	// Reads return one cycle after grant, stores return nothing
	always_ff @(posedge clk) begin
		if (reset) begin
			fetch_valid <= 1'b0;
			data_valid  <= 1'b0;
		end else begin
			fetch_valid <= fetch_grant;
			data_valid  <= load_capture;
		end
	end

endmodule

// File: load_align.sv
`timescale 1ns/1ps

module load_align import mem_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        load_capture,
	input  load_op_t    data_load,
	input  logic [31:0] raw,
	output logic [31:0] result
);

	load_op_t load_q;

	// The code is taken at grant and used when the rotated word comes back
	always_ff @(posedge clk) begin
		if (reset) begin
			load_q <= load_word;
		end else if (load_capture) begin
			load_q <= data_load;
		end
	end

	// Byte 0 of the rotated word is always the addressed byte
	always_comb begin
		case (load_q)
			load_byte: begin
				result = {{24{raw[7]}}, raw[7:0]};
			end
			load_half: begin
				result = {{16{raw[15]}}, raw[15:0]};
			end
			load_byte_u: begin
				result = {24'h000000, raw[7:0]};
			end
			load_half_u: begin
				result = {16'h0000, raw[15:0]};
			end
			default: begin
				result = raw;
			end
		endcase
	end

endmodule

// File: mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem import mem_pkg::*; (
	input  logic                      clk,
	input  logic                      reset,

	// Instruction fetch port
	input  logic                      fetch_req,
	input  logic [mem_addr_width-1:0] fetch_addr,
	output logic                      fetch_grant,
	output logic                      fetch_valid,
	output logic [31:0]               fetch_data,

	// Load/store data port
	input  logic                      data_req,
	input  logic [mem_addr_width-1:0] data_addr,
	input  store_op_t                 data_store,
	input  load_op_t                  data_load,
	input  logic [31:0]               data_wdata,
	output logic                      data_grant,
	output logic                      data_valid,
	output logic [31:0]               data_rdata
);

	logic                      mem_en;
	logic [mem_addr_width-1:0] mem_addr;
	store_op_t                 mem_store;
	logic [31:0]               mem_wdata;
	logic [31:0]               mem_rdata;
	logic                      load_capture;

	// ********************
	// Shared port
	// ********************

	mem_arbiter u_arbiter (
		.clk          (clk),
		.reset        (reset),
		.fetch_req    (fetch_req),
		.fetch_addr   (fetch_addr),
		.data_req     (data_req),
		.data_addr    (data_addr),
		.data_store   (data_store),
		.data_wdata   (data_wdata),
		.fetch_grant  (fetch_grant),
		.data_grant   (data_grant),
		.mem_en       (mem_en),
		.mem_addr     (mem_addr),
		.mem_store    (mem_store),
		.mem_wdata    (mem_wdata),
		.fetch_valid  (fetch_valid),
		.data_valid   (data_valid),
		.load_capture (load_capture)
	);

	mem_interface u_mem (
		.clk   (clk),
		.reset (reset),
		.en    (mem_en),
		.addr  (mem_addr),
		.wdata (mem_wdata),
		.store (mem_store),
		.rdata (mem_rdata)
	);

	// Fetches take the rotated word as it is
	assign fetch_data = mem_rdata;

	load_align u_align (
		.clk          (clk),
		.reset        (reset),
		.load_capture (load_capture),
		.data_load    (data_load),
		.raw          (mem_rdata),
		.result       (data_rdata)
	);

endmodule

// File: tb_mem_model.svh
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

// ********************
// Reference model
// ********************

typedef enum logic {win_fetch, win_data} winner_t;

localparam int model_bytes_total = 1 << mem_addr_width;

logic [7:0] model_bytes [0:model_bytes_total-1];

// A fetch as the last contest winner makes the data port win the next one
winner_t last_winner = win_fetch;

function automatic int store_length(input store_op_t op);
	case (op)
		store_byte: return 1;
		store_half: return 2;
		store_word: return 4;
		default:    return 0;
	endcase
endfunction

function automatic void model_store(input logic [mem_addr_width-1:0] addr, input store_op_t op,
		input logic [31:0] wdata);
	logic [mem_addr_width-1:0] byte_addr;
	byte_addr = addr;
	for (int i = 0; i < store_length(op); i++) begin
		model_bytes[byte_addr] = wdata[8*i +: 8];
		byte_addr++;
	end
endfunction

// Bytes at addr, addr+1, addr+2, addr+3 with the address wrapping at the top
function automatic logic [31:0] model_fetch(input logic [mem_addr_width-1:0] addr);
	logic [31:0]               word;
	logic [mem_addr_width-1:0] byte_addr;
	byte_addr = addr;
	for (int i = 0; i < num_lanes; i++) begin
		word[8*i +: 8] = model_bytes[byte_addr];
		byte_addr++;
	end
	return word;
endfunction

function automatic logic [31:0] model_load(input logic [mem_addr_width-1:0] addr,
		input load_op_t op);
	logic [31:0] word;
	word = model_fetch(addr);
	case (op)
		load_byte:   return 32'($signed(word[7:0]));
		load_half:   return 32'($signed(word[15:0]));
		load_byte_u: return 32'(word[7:0]);
		load_half_u: return 32'(word[15:0]);
		default:     return word;
	endcase
endfunction

function automatic void predict_grants(input logic f_req, input logic d_req,
		output logic exp_f, output logic exp_d);
	if (f_req && d_req) begin
		exp_d = (last_winner == win_fetch);
		exp_f = !exp_d;
		last_winner = exp_d ? win_data : win_fetch;
	end else begin
		exp_f = f_req;
		exp_d = d_req;
	end
endfunction

`endif

// File: tb_mem_subsystem.sv
`timescale 1ns/1ps

module tb_mem_subsystem import mem_pkg::*;;

	localparam int reset_cycles      = 16;
	localparam int fill_cycles       = 2 * 256 + 2;
	localparam int misaligned_cycles = 300 + 2;
	localparam int store_load_cycles = 150 * 6 + 2;
	localparam int contention_cycles = 1000 + 4;
	localparam int reset_test_cycles = 120;
	localparam int timeout_limit     = 2 * (reset_cycles + fill_cycles + misaligned_cycles +
		store_load_cycles + contention_cycles + reset_test_cycles);

	logic                      clk;
	logic                      reset;
	logic                      fetch_req;
	logic [mem_addr_width-1:0] fetch_addr;
	logic                      fetch_grant;
	logic                      fetch_valid;
	logic [31:0]               fetch_data;
	logic                      data_req;
	logic [mem_addr_width-1:0] data_addr;
	store_op_t                 data_store;
	load_op_t                  data_load;
	logic [31:0]               data_wdata;
	logic                      data_grant;
	logic                      data_valid;
	logic [31:0]               data_rdata;

	int          pass_count = 0;
	int          error_count = 0;
	int          errors_before = 0;
	int          cycle_count = 0;

	// Responses expected at the next negedge
	logic        fetch_pending;
	logic        data_pending;
	logic [31:0] fetch_expect;
	logic [31:0] data_expect;

	load_op_t load_kinds [5] = '{load_byte, load_half, load_word, load_byte_u, load_half_u};

	`include "tb_mem_model.svh"

	mem_subsystem UUT (
		.clk         (clk),
		.reset       (reset),
		.fetch_req   (fetch_req),
		.fetch_addr  (fetch_addr),
		.fetch_grant (fetch_grant),
		.fetch_valid (fetch_valid),
		.fetch_data  (fetch_data),
		.data_req    (data_req),
		.data_addr   (data_addr),
		.data_store  (data_store),
		.data_load   (data_load),
		.data_wdata  (data_wdata),
		.data_grant  (data_grant),
		.data_valid  (data_valid),
		.data_rdata  (data_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", timeout_limit);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// ********************
	// Checks
	// ********************

	task automatic compare_value(input string what, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, actual, expected);
			error_count++;
		end else begin
			pass_count++;
		end
	endtask

	task automatic check_responses();
		if (fetch_valid !== fetch_pending) begin
			if (fetch_pending)
				$display("At %0t ns a granted fetch got no fetch_valid pulse", $time);
			else
				$display("At %0t ns fetch_valid pulsed with no fetch in flight", $time);
			error_count++;
		end else if (fetch_pending) begin
			compare_value("fetch_data", fetch_data, fetch_expect);
		end
		if (data_valid !== data_pending) begin
			if (data_pending)
				$display("At %0t ns a granted load got no data_valid pulse", $time);
			else
				$display("At %0t ns data_valid pulsed with no load in flight", $time);
			error_count++;
		end else if (data_pending) begin
			compare_value("data_rdata", data_rdata, data_expect);
		end
	endtask

	// ********************
	// Stimulus
	// ********************

	function automatic logic [mem_addr_width-1:0] rand_addr();
		logic [31:0] r;
		r = $urandom;
		return r[mem_addr_width-1:0];
	endfunction

	function automatic store_op_t rand_store_op();
		case ($urandom % 3)
			0:       return store_byte;
			1:       return store_half;
			default: return store_word;
		endcase
	endfunction

	function automatic load_op_t rand_load_op();
		return load_kinds[$urandom % 5];
	endfunction

	// Starts 1 ns after a rising edge and returns 1 ns after the next one
	task automatic run_cycle(input logic f_req, input logic [mem_addr_width-1:0] f_addr,
			input logic d_req, input logic [mem_addr_width-1:0] d_addr,
			input store_op_t d_store, input load_op_t d_load, input logic [31:0] d_wdata,
			output logic f_granted, output logic d_granted);
		logic exp_f;
		logic exp_d;
		fetch_req  = f_req;
		fetch_addr = f_addr;
		data_req   = d_req;
		data_addr  = d_addr;
		data_store = d_store;
		data_load  = d_load;
		data_wdata = d_wdata;
		@(negedge clk);
		check_responses();
		predict_grants(f_req, d_req, exp_f, exp_d);
		compare_value("fetch_grant", 32'(fetch_grant), 32'(exp_f));
		compare_value("data_grant", 32'(data_grant), 32'(exp_d));
		fetch_pending = exp_f;
		data_pending  = exp_d && (d_store == store_none);
		if (exp_f)
			fetch_expect = model_fetch(f_addr);
		if (data_pending)
			data_expect = model_load(d_addr, d_load);
		if (exp_d && d_store != store_none)
			model_store(d_addr, d_store, d_wdata);
		f_granted = exp_f;
		d_granted = exp_d;
		@(posedge clk);
		#1;
	endtask

	task automatic idle_cycle();
		logic f_g;
		logic d_g;
		run_cycle(1'b0, '0, 1'b0, '0, store_none, load_word, '0, f_g, d_g);
	endtask

	task automatic apply_reset(input int cycles);
		reset = 1'b1;
		fetch_req = 1'b0;
		data_req = 1'b0;
		fetch_pending = 1'b0;
		data_pending = 1'b0;
		repeat (cycles) begin
			@(negedge clk);
			if (fetch_valid !== 1'b0 || data_valid !== 1'b0) begin
				$display("At %0t ns a valid output is high while reset is held", $time);
				error_count++;
			end
			if (fetch_grant !== 1'b0 || data_grant !== 1'b0) begin
				$display("At %0t ns a grant output is high while reset is held", $time);
				error_count++;
			end
			@(posedge clk);
			#1;
		end
		reset = 1'b0;
		last_winner = win_fetch;
	endtask

	task automatic report_test(input string name);
		$display("Test %s finished with %0d errors", name, error_count - errors_before);
		errors_before = error_count;
	endtask

	// Each requester keeps its request and operands until it is granted
	task automatic random_traffic(input int cycles);
		logic                      f_req;
		logic                      d_req;
		logic                      f_hold;
		logic                      d_hold;
		logic                      f_g;
		logic                      d_g;
		logic [mem_addr_width-1:0] f_addr;
		logic [mem_addr_width-1:0] d_addr;
		store_op_t                 d_store;
		load_op_t                  d_load;
		logic [31:0]               d_wdata;
		int                        count;
		f_hold = 1'b0;
		d_hold = 1'b0;
		f_req = 1'b0;
		d_req = 1'b0;
		f_addr = '0;
		d_addr = '0;
		d_store = store_none;
		d_load = load_word;
		d_wdata = '0;
		count = 0;
		while (count < cycles || f_hold || d_hold) begin
			if (!f_hold) begin
				f_req = (count < cycles) && ($urandom % 4 != 0);
				f_addr = rand_addr();
			end
			if (!d_hold) begin
				d_req = (count < cycles) && ($urandom % 4 != 0);
				d_addr = rand_addr();
				d_store = ($urandom % 3 == 0) ? rand_store_op() : store_none;
				d_load = rand_load_op();
				d_wdata = $urandom;
			end
			run_cycle(f_req, f_addr, d_req, d_addr, d_store, d_load, d_wdata, f_g, d_g);
			f_hold = f_req && !f_g;
			d_hold = d_req && !d_g;
			count++;
		end
	endtask

	// ********************
	// Tests
	// ********************

	task automatic fill_test();
		logic f_g;
		logic d_g;
		for (int i = 0; i < 256; i++)
			run_cycle(1'b0, '0, 1'b1, 10'(4 * i), store_word, load_word, $urandom, f_g, d_g);
		for (int i = 0; i < 256; i++)
			run_cycle(1'b1, 10'(4 * i), 1'b0, '0, store_none, load_word, '0, f_g, d_g);
		idle_cycle();
		report_test("fill and aligned read-back");
	endtask

	task automatic misaligned_test();
		logic                      f_g;
		logic                      d_g;
		logic [mem_addr_width-1:0] addr;
		for (int i = 0; i < 300; i++) begin
			addr = (i < 3) ? 10'd1021 + 10'(i) : rand_addr();
			run_cycle(1'b1, addr, 1'b0, '0, store_none, load_word, '0, f_g, d_g);
		end
		idle_cycle();
		report_test("misaligned fetches");
	endtask

	task automatic store_load_test();
		logic                      f_g;
		logic                      d_g;
		logic [mem_addr_width-1:0] addr;
		logic [mem_addr_width-1:0] load_addr;
		for (int i = 0; i < 150; i++) begin
			addr = (i < 3) ? 10'd1021 + 10'(i) : rand_addr();
			run_cycle(1'b0, '0, 1'b1, addr, rand_store_op(), load_word, $urandom, f_g, d_g);
			// Loads land around the store so that both touched and untouched bytes are seen
			for (int k = 0; k < 5; k++) begin
				load_addr = addr - 10'd3 + 10'($urandom % 7);
				run_cycle(1'b0, '0, 1'b1, load_addr, store_none, load_kinds[k], '0, f_g, d_g);
			end
		end
		idle_cycle();
		report_test("stores and loads of every size");
	endtask

	task automatic reset_test();
		logic                      f_g;
		logic                      d_g;
		logic [mem_addr_width-1:0] f_addr;
		logic [mem_addr_width-1:0] d_addr;
		random_traffic(40);
		// The data port takes the last contest before the reset so the reset has a winner to clear
		f_addr = rand_addr();
		d_addr = rand_addr();
		run_cycle(1'b1, f_addr, 1'b1, d_addr, store_none, load_word, '0, f_g, d_g);
		if (!d_g) begin
			f_addr = rand_addr();
			run_cycle(1'b1, f_addr, 1'b1, d_addr, store_none, load_word, '0, f_g, d_g);
		end
		run_cycle(1'b1, f_addr, 1'b0, '0, store_none, load_word, '0, f_g, d_g);
		idle_cycle();
		apply_reset(4);
		repeat (3) idle_cycle();
		f_addr = rand_addr();
		run_cycle(1'b1, f_addr, 1'b1, rand_addr(), store_none, load_word, '0, f_g, d_g);
		run_cycle(1'b1, f_addr, 1'b0, '0, store_none, load_word, '0, f_g, d_g);
		repeat (30)
			run_cycle(1'b1, rand_addr(), 1'b0, '0, store_none, load_word, '0, f_g, d_g);
		repeat (20)
			run_cycle(1'b0, '0, 1'b1, rand_addr(), store_none, rand_load_op(), '0, f_g, d_g);
		idle_cycle();
		report_test("reset mid-traffic");
	endtask

	initial begin
		void'($urandom(84));
		reset = 1'b1;
		fetch_req = 1'b0;
		fetch_addr = '0;
		data_req = 1'b0;
		data_addr = '0;
		data_store = store_none;
		data_load = load_word;
		data_wdata = '0;
		fetch_pending = 1'b0;
		data_pending = 1'b0;
		fetch_expect = '0;
		data_expect = '0;
		apply_reset(reset_cycles);

		fill_test();
		misaligned_test();
		store_load_test();
		random_traffic(1000);
		idle_cycle();
		report_test("contention");
		reset_test();

		$display("Checks passed: %0d, errors: %0d", pass_count, error_count);
		if (error_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// File: build.f
+incdir+.
mem_pkg.sv
byte_bank.sv
mem_interface.sv
mem_arbiter.sv
load_align.sv
mem_subsystem.sv
tb_mem_subsystem.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

rm -f sim.log
verilator --binary --timing -f build.f --top-module tb_mem_subsystem -o sim_mem_subsystem \
	&& ./obj_dir/sim_mem_subsystem > sim.log 2>&1 \
	|| echo "Build or simulation stopped early"

grep -q "SIMULATION PASSED" sim.log 2>/dev/null && echo "Result: pass" && exit 0
echo "Result: fail"
exit 1
